//--- bench/ctrl_trace.txt
// inputs:   instrValid instr aluZero aluPositive
// expected: instrReady pcWrite pcSrc fwdA fwdB regWrite regDest (one line per cycle)
1 00221820 0 0  0 0 0 0 0 0 00
1 00221820 0 0  1 1 0 0 0 0 00
1 20640005 0 0  1 1 0 0 0 0 00
1 00642822 0 0  1 1 0 1 0 0 00
1 30050007 0 0  1 1 0 2 1 1 03
1 00a03825 0 0  1 1 0 0 0 1 04
1 20e00001 0 0  1 1 0 1 0 1 05
1 00004020 0 0  1 1 0 1 0 1 05
1 8c290000 0 0  1 1 0 0 0 1 07
1 01215020 0 0  0 0 0 0 0 1 00
1 01215020 0 0  1 1 0 0 0 1 08
1 10220004 0 0  1 1 0 2 0 1 09
1 14640008 1 0  0 1 1 0 0 0 00
1 14640008 0 0  0 0 0 0 0 1 0a
1 14640008 0 0  1 1 0 0 0 0 00
1 1ca00003 1 0  0 0 0 0 0 0 00
1 1ca00003 0 0  1 1 0 0 0 0 00
1 08000010 0 1  0 1 1 0 0 0 00
1 08000010 0 0  0 0 0 0 0 0 00
1 08000010 0 0  1 1 2 0 0 0 00
1 03e00008 0 0  0 0 0 0 0 0 00
1 03e00008 0 0  0 0 0 0 0 0 00
1 03e00008 0 0  1 1 3 0 0 0 00
1 00e55820 0 0  0 0 0 0 0 0 00
1 00e55820 0 0  0 0 0 0 0 0 00
1 00e55820 0 0  1 1 0 0 0 0 00
0 00000000 0 0  1 0 0 0 0 0 00
0 00000000 0 0  1 0 0 0 0 0 00
0 00000000 0 0  1 0 0 0 0 1 0b
0 00000000 0 0  1 0 0 0 0 0 00

//--- bench/pipeControl_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_defs.svh"

module pipeControl_tb
    import isaPkg::*, ctrlPkg::*;
();

    localparam int NumSteps      = 30;
    localparam int Fields        = 11;     // tokens per trace line
    localparam int ResetCycles   = 8;
    localparam int TimeoutCycles = ResetCycles + NumSteps + 20;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       instrValid;
    logic [`INSTR_W-1:0]        instr;
    logic                       aluZero;
    logic                       aluPositive;
    logic                       instrReady;
    logic                       pcWrite;
    pcSrcT                      pcSrc;
    aluOpT                      aluOp;
    logic                       aluImm;
    fwdSelT                     fwdA;
    fwdSelT                     fwdB;
    logic                       memRead;
    logic                       memWrite;
    logic                       regWrite;
    logic [`REG_ADDR_W-1:0]     regDest;
    logic                       memToReg;

    logic [31:0]                traceMem [0:NumSteps*Fields-1];
    logic                       loadTaken [0:NumSteps-1];
    logic                       storeTaken [0:NumSteps-1];
    int                         errors;
    int                         checks;
    int                         cycleCount;

    pipeControl DUT (
        .clk(clk), .rst_n(rst_n), .instrValid(instrValid), .instr(instr),
        .aluZero(aluZero), .aluPositive(aluPositive), .instrReady(instrReady),
        .pcWrite(pcWrite), .pcSrc(pcSrc), .aluOp(aluOp), .aluImm(aluImm),
        .fwdA(fwdA), .fwdB(fwdB), .memRead(memRead), .memWrite(memWrite),
        .regWrite(regWrite), .regDest(regDest), .memToReg(memToReg)
    );

    initial
    begin
        forever #4 clk = ~clk;     // 8 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic reportMismatch(input string what, input string got, input string exp);
        errors = errors + 1;
        $display("FAILED at %0t ns: %s is %s, expected %s", $time, what, got, exp);
    endtask

    task automatic checkReady(input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp)
            reportMismatch("instrReady", $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    // source only matters when the PC is written
    task automatic checkPc(input logic gotWr, input logic expWr,
                           input pcSrcT gotSrc, input pcSrcT expSrc);
        checks = checks + 1;
        if (gotWr !== expWr)
            reportMismatch("pcWrite", $sformatf("%b", gotWr), $sformatf("%b", expWr));
        else if (expWr && gotSrc !== expSrc)
            reportMismatch("pcSrc", gotSrc.name(), expSrc.name());
    endtask

    task automatic checkFwd(input string which, input fwdSelT got, input fwdSelT exp);
        checks = checks + 1;
        if (got !== exp)
            reportMismatch(which, got.name(), exp.name());
    endtask

    task automatic checkReg(input logic gotWe, input logic expWe,
                            input logic [`REG_ADDR_W-1:0] gotDest,
                            input logic [`REG_ADDR_W-1:0] expDest);
        checks = checks + 1;
        if (gotWe !== expWe)
            reportMismatch("regWrite", $sformatf("%b", gotWe), $sformatf("%b", expWe));
        else if (expWe && gotDest !== expDest)
            reportMismatch("regDest", $sformatf("%0d", gotDest), $sformatf("%0d", expDest));
    endtask

    task automatic checkAlu(input aluOpT gotOp, input aluOpT expOp,
                            input logic gotImm, input logic expImm);
        checks = checks + 1;
        if (gotOp !== expOp)
            reportMismatch("aluOp", gotOp.name(), expOp.name());
        if (gotImm !== expImm)
            reportMismatch("aluImm", $sformatf("%b", gotImm), $sformatf("%b", expImm));
    endtask

    task automatic checkMem(input logic gotRd, input logic expRd,
                            input logic gotWr, input logic expWr,
                            input logic gotToReg, input logic expToReg);
        checks = checks + 1;
        if (gotRd !== expRd)
            reportMismatch("memRead", $sformatf("%b", gotRd), $sformatf("%b", expRd));
        if (gotWr !== expWr)
            reportMismatch("memWrite", $sformatf("%b", gotWr), $sformatf("%b", expWr));
        if (gotToReg !== expToReg)
            reportMismatch("memToReg", $sformatf("%b", gotToReg), $sformatf("%b", expToReg));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // trace access
    ////////////////////////////////////////////////////////////////////////////

    task automatic driveStep(input int step);
        int base;
        base = step * Fields;
        instrValid  <= traceMem[base][0];
        instr       <= traceMem[base+1];
        aluZero     <= traceMem[base+2][0];
        aluPositive <= traceMem[base+3][0];
    endtask

    // ALU controls follow the offered word, jumps leave them unused
    task automatic compareAlu(input int step);
        instrWordT w;
        logic      isJump;
        aluOpT     expOp;
        logic      expImm;
        w      = instrWordT'(traceMem[step*Fields+1]);
        isJump = (w.i.opcode == OP_J) || (w.i.opcode == OP_RTYPE && w.r.funct == FN_JR);
        expImm = w.i.opcode inside {OP_ADDI, OP_ANDI, OP_LW, OP_SW};
        if (w.i.opcode inside {OP_BEQ, OP_BNE, OP_BGTZ})
            expOp = ALU_SUB;            // compare by subtraction
        else if (w.i.opcode == OP_ANDI || w.i.opcode == OP_RTYPE)
            expOp = ALU_FUNCT;
        else
            expOp = ALU_ADD;            // addi and address arithmetic
        if (traceMem[step*Fields][0] && !isJump)
            checkAlu(aluOp, expOp, aluImm, expImm);
    endtask

    // accepted words reach memory two steps on and writeback three steps on
    task automatic compareMem(input int step);
        int     base;
        opcodeT op;
        logic   taken;
        logic   expRd;
        logic   expWr;
        logic   expToReg;
        base             = step * Fields;
        op               = opcodeT'(traceMem[base+1][31:26]);
        taken            = traceMem[base][0] && traceMem[base+4][0];
        loadTaken[step]  = taken && (op == OP_LW);
        storeTaken[step] = taken && (op == OP_SW);
        expRd            = (step >= 2) ? loadTaken[step-2] : 1'b0;
        expWr            = (step >= 2) ? storeTaken[step-2] : 1'b0;
        expToReg         = (step >= 3) ? loadTaken[step-3] : 1'b0;
        checkMem(memRead, expRd, memWrite, expWr, memToReg, expToReg);
    endtask

    task automatic compareStep(input int step);
        int base;
        base = step * Fields;
        checkReady(instrReady, traceMem[base+4][0]);
        checkPc(pcWrite, traceMem[base+5][0], pcSrc, pcSrcT'(traceMem[base+6][1:0]));
        checkFwd("fwdA", fwdA, fwdSelT'(traceMem[base+7][1:0]));
        checkFwd("fwdB", fwdB, fwdSelT'(traceMem[base+8][1:0]));
        checkReg(regWrite, traceMem[base+9][0], regDest, traceMem[base+10][`REG_ADDR_W-1:0]);
        compareAlu(step);
        compareMem(step);
    endtask

    task automatic checkResetQuiet();
        checkReady(instrReady, 1'b0);
        checkPc(pcWrite, 1'b0, pcSrc, PC_NEXT);
        checkReg(regWrite, 1'b0, regDest, '0);
        checkMem(memRead, 1'b0, memWrite, 1'b0, memToReg, 1'b0);
    endtask

    // hard stop if the run stalls
    initial
    begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles)
        begin
            @(posedge clk);
            cycleCount = cycleCount + 1;
        end
        $display("timeout: trace not finished after %0d cycles", TimeoutCycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        errors      = 0;
        checks      = 0;
        rst_n       = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        aluZero     = 1'b0;
        aluPositive = 1'b0;
        $readmemh("bench/ctrl_trace.txt", traceMem);
        if ($isunknown(traceMem[NumSteps*Fields-1]))
        begin
            errors = errors + 1;
            $display("trace file is missing or holds fewer than %0d steps", NumSteps);
        end

        repeat (ResetCycles)
        begin
            @(negedge clk);
            checkResetQuiet();
        end

        // one trace line per cycle, outputs read at the falling edge
        for (int step = 0; step < NumSteps; step++)
        begin
            @(posedge clk);
            if (step == 0)
                rst_n <= 1'b1;
            driveStep(step);
            @(negedge clk);
            compareStep(step);
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/pipeSequencer.sv
verilog/redirectTimer.sv
verilog/hazardUnit.sv
verilog/branchResolver.sv
verilog/pipeControl.sv
bench/pipeControl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the controller testbench with Verilator, run it, then scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module pipeControl_tb -o pipeControl_sim

./obj_dir/pipeControl_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log
then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed"
    exit 1
fi

//--- verilog/branchResolver.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_defs.svh"

module branchResolver
    import isaPkg::*, ctrlPkg::*;
(
    input  wire                 accept,
    input  wire instrClassT     instrClass,
    input  wire instrClassT     exClass,
    input  wire                 aluZero,        // rs - rt == 0
    input  wire                 aluPositive,    // rs > 0
    output logic                branchTaken,
    output logic                pcWrite,
    output pcSrcT               pcSrc
);

    assign branchTaken = ((exClass == CLS_BEQ)  &&  aluZero) ||
                         ((exClass == CLS_BNE)  && !aluZero) ||
                         ((exClass == CLS_BGTZ) &&  aluPositive);

    always_comb
    begin
        pcWrite = 1'b1;
        pcSrc   = PC_NEXT;
        if (branchTaken)
            pcSrc = PC_BRANCH;      // fetch is closed, nothing else competes
        else if (accept && instrClass == CLS_JUMP)
            pcSrc = PC_JUMP;
        else if (accept && instrClass == CLS_JR)
            pcSrc = PC_REG;
        else if (!accept)
            pcWrite = 1'b0;
    end

endmodule

`default_nettype wire

//--- verilog/ctrlPkg.sv
`default_nettype none
`include "pipe_defs.svh"

package ctrlPkg;

    ////////////////////////////////////////////////////////////////////////////
    // issue sequencer
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RUN,            // fetch open
        BRANCH_WAIT,    // branch sitting in execute
        REDIRECT        // waiting for the hold timer
    } seqStateT;

    ////////////////////////////////////////////////////////////////////////////
    // datapath selects
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        PC_NEXT   = 2'b00,  // pc + 4
        PC_BRANCH = 2'b01,  // pc + offset
        PC_JUMP   = 2'b10,  // 26-bit target
        PC_REG    = 2'b11   // rs value
    } pcSrcT;

    // ALU operand source
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_MEM = 2'b01,
        FWD_WB  = 2'b10
    } fwdSelT;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_SUB   = 2'b01,
        ALU_FUNCT = 2'b10   // ALU decodes the funct field itself
    } aluOpT;

endpackage

`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_defs.svh"

module hazardUnit
    import isaPkg::*, ctrlPkg::*;
(
    input  wire                         instrValid,
    input  wire [`REG_ADDR_W-1:0]       rsAddr,
    input  wire [`REG_ADDR_W-1:0]       rtAddr,
    input  wire instrClassT             exClass,
    input  wire [`REG_ADDR_W-1:0]       exRs,
    input  wire [`REG_ADDR_W-1:0]       exRt,
    input  wire [`REG_ADDR_W-1:0]       exDest,
    input  wire instrClassT             memClass,
    input  wire [`REG_ADDR_W-1:0]       memDest,
    input  wire instrClassT             wbClass,
    input  wire [`REG_ADDR_W-1:0]       wbDest,
    output logic                        loadUse,
    output fwdSelT                      fwdA,
    output fwdSelT                      fwdB
);

    logic exLive;
    logic memFwdOk;
    logic wbFwdOk;

    // memory slot wins over writeback
    function automatic fwdSelT pickFwd(
        input logic [`REG_ADDR_W-1:0] src,
        input logic                   memOk,
        input logic [`REG_ADDR_W-1:0] memAddr,
        input logic                   wbOk,
        input logic [`REG_ADDR_W-1:0] wbAddr
    );
        fwdSelT sel;
        sel = FWD_REG;
        if (memOk && memAddr == src)
            sel = FWD_MEM;
        else if (wbOk && wbAddr == src)
            sel = FWD_WB;
        return sel;
    endfunction

    assign exLive = (exClass != CLS_NONE);

    // load data not ready yet in memory, only ALU results forward from there
    assign memFwdOk = (memClass inside {CLS_ALU_REG, CLS_ALU_IMM}) && (memDest != '0);
    assign wbFwdOk  = (wbClass inside {CLS_ALU_REG, CLS_ALU_IMM, CLS_LOAD}) && (wbDest != '0);

    assign fwdA = exLive ? pickFwd(exRs, memFwdOk, memDest, wbFwdOk, wbDest) : FWD_REG;
    assign fwdB = exLive ? pickFwd(exRt, memFwdOk, memDest, wbFwdOk, wbDest) : FWD_REG;

    // offered word needs a load result that is still one stage away
    assign loadUse = instrValid && (exClass == CLS_LOAD) && (exDest != '0) &&
                     ((exDest == rsAddr) || (exDest == rtAddr));

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_defs.svh"

module instrDecoder
    import isaPkg::*, ctrlPkg::*;
(
    input  wire instrWordT              instr,
    output instrClassT                  instrClass,
    output logic [`REG_ADDR_W-1:0]      rsAddr,
    output logic [`REG_ADDR_W-1:0]      rtAddr,
    output logic [`REG_ADDR_W-1:0]      destAddr,
    output aluOpT                       aluOp,
    output logic                        aluImm
);

    // unused source fields are forced to zero so they never stall or forward
    always_comb
    begin
        instrClass = CLS_NONE;
        rsAddr     = instr.i.rs;
        rtAddr     = instr.i.rt;
        destAddr   = '0;
        aluOp      = ALU_ADD;
        aluImm     = 1'b0;
        case (instr.i.opcode)
            OP_RTYPE:
            begin
                if (instr.r.funct == FN_JR)
                begin
                    instrClass = CLS_JR;
                    rtAddr     = '0;
                end
                else if (instr.r.funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR})
                begin
                    instrClass = CLS_ALU_REG;
                    destAddr   = instr.r.rd;
                    aluOp      = ALU_FUNCT;
                end
                else
                begin
                    rsAddr = '0;    // unknown funct, treat as empty
                    rtAddr = '0;
                end
            end
            OP_ADDI, OP_ANDI:
            begin
                instrClass = CLS_ALU_IMM;
                destAddr   = instr.i.rt;
                rtAddr     = '0;
                aluImm     = 1'b1;
                // andi picks its logic op from the opcode in the ALU decoder
                aluOp      = (instr.i.opcode == OP_ANDI) ? ALU_FUNCT : ALU_ADD;
            end
            OP_LW:
            begin
                instrClass = CLS_LOAD;
                destAddr   = instr.i.rt;
                rtAddr     = '0;
                aluImm     = 1'b1;          // base + offset
            end
            OP_SW:
            begin
                instrClass = CLS_STORE;     // rt stays, it is the store data
                aluImm     = 1'b1;
            end
            OP_BEQ, OP_BNE:
            begin
                instrClass = (instr.i.opcode == OP_BEQ) ? CLS_BEQ : CLS_BNE;
                aluOp      = ALU_SUB;
            end
            OP_BGTZ:
            begin
                instrClass = CLS_BGTZ;
                rtAddr     = '0;
                aluOp      = ALU_SUB;
            end
            OP_J:
            begin
                instrClass = CLS_JUMP;
                rsAddr     = '0;
                rtAddr     = '0;
            end
            default:
            begin
                rsAddr = '0;
                rtAddr = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/isaPkg.sv
`default_nettype none
`include "pipe_defs.svh"

package isaPkg;

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_BGTZ  = 6'h07,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeT;

    // funct codes under OP_RTYPE
    typedef enum logic [5:0] {
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25
    } functT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [4:0]              shamt;
        functT                   funct;
    } instrRT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [15:0]             imm;
    } instrIT;

    // same 32 bits, register view and immediate view
    typedef union packed {
        instrRT r;
        instrIT i;
    } instrWordT;

    typedef enum logic [3:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BEQ,
        CLS_BNE,
        CLS_BGTZ,
        CLS_JUMP,
        CLS_JR,
        CLS_NONE        // bubble or empty slot
    } instrClassT;

endpackage

`default_nettype wire

//--- verilog/pipeControl.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_defs.svh"

module pipeControl
    import isaPkg::*, ctrlPkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         instrValid,
    input  wire [`INSTR_W-1:0]          instr,
    input  wire                         aluZero,
    input  wire                         aluPositive,
    output logic                        instrReady,
    output logic                        pcWrite,
    output pcSrcT                       pcSrc,
    output aluOpT                       aluOp,
    output logic                        aluImm,
    output fwdSelT                      fwdA,
    output fwdSelT                      fwdB,
    output logic                        memRead,
    output logic                        memWrite,
    output logic                        regWrite,
    output logic [`REG_ADDR_W-1:0]      regDest,
    output logic                        memToReg
);

    instrClassT              instrClass, exClass, memClass, wbClass;
    logic [`REG_ADDR_W-1:0]  rsAddr, rtAddr, destAddr;
    logic [`REG_ADDR_W-1:0]  exRs, exRt, exDest, memDest, wbDest;
    logic [`HOLD_W-1:0]      timerValue;
    logic                    accept, loadUse, branchTaken, timerLoad, timerBusy;
    seqStateT                seqState;

    instrDecoder uDecoder (
        .instr(instrWordT'(instr)), .instrClass(instrClass), .rsAddr(rsAddr),
        .rtAddr(rtAddr), .destAddr(destAddr), .aluOp(aluOp), .aluImm(aluImm)
    );

    pipeSequencer uSequencer (
        .clk(clk), .rst_n(rst_n), .instrValid(instrValid), .instrClass(instrClass),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .destAddr(destAddr), .loadUse(loadUse),
        .branchTaken(branchTaken), .timerBusy(timerBusy), .instrReady(instrReady),
        .accept(accept), .state(seqState), .timerLoad(timerLoad), .timerValue(timerValue),
        .exClass(exClass), .exRs(exRs), .exRt(exRt), .exDest(exDest),
        .memClass(memClass), .memDest(memDest), .wbClass(wbClass), .wbDest(wbDest)
    );

    redirectTimer uTimer (
        .clk(clk), .rst_n(rst_n), .load(timerLoad), .value(timerValue), .busy(timerBusy)
    );

    hazardUnit uHazard (
        .instrValid(instrValid), .rsAddr(rsAddr), .rtAddr(rtAddr), .exClass(exClass),
        .exRs(exRs), .exRt(exRt), .exDest(exDest), .memClass(memClass), .memDest(memDest),
        .wbClass(wbClass), .wbDest(wbDest), .loadUse(loadUse), .fwdA(fwdA), .fwdB(fwdB)
    );

    branchResolver uBranch (
        .accept(accept), .instrClass(instrClass), .exClass(exClass), .aluZero(aluZero),
        .aluPositive(aluPositive), .branchTaken(branchTaken), .pcWrite(pcWrite),
        .pcSrc(pcSrc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory and writeback strobes from the slot classes
    ////////////////////////////////////////////////////////////////////////////

    assign memRead  = (memClass == CLS_LOAD);
    assign memWrite = (memClass == CLS_STORE);
    assign regWrite = wbClass inside {CLS_ALU_REG, CLS_ALU_IMM, CLS_LOAD};
    assign memToReg = (wbClass == CLS_LOAD);
    assign regDest  = wbDest;

    // load-use stall keeps a load in memory from feeding a live execute source
    assert property (@(posedge clk) disable iff (!rst_n)
        memClass == CLS_LOAD && memDest != '0 && exClass != CLS_NONE
            |-> memDest != exRs && memDest != exRt)
        else $error("load result needed in execute one cycle too early");

    // a branch redirect only comes out of the branch wait state
    assert property (@(posedge clk) disable iff (!rst_n)
        pcWrite && pcSrc == PC_BRANCH |-> seqState == BRANCH_WAIT)
        else $error("branch redirect outside BRANCH_WAIT");

endmodule

`default_nettype wire

//--- verilog/pipeSequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_defs.svh"

module pipeSequencer
    import isaPkg::*, ctrlPkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         instrValid,
    input  wire instrClassT             instrClass,
    input  wire [`REG_ADDR_W-1:0]       rsAddr,
    input  wire [`REG_ADDR_W-1:0]       rtAddr,
    input  wire [`REG_ADDR_W-1:0]       destAddr,
    input  wire                         loadUse,
    input  wire                         branchTaken,
    input  wire                         timerBusy,
    output logic                        instrReady,
    output logic                        accept,
    output seqStateT                    state,
    output logic                        timerLoad,
    output logic [`HOLD_W-1:0]          timerValue,
    output instrClassT                  exClass,
    output logic [`REG_ADDR_W-1:0]      exRs,
    output logic [`REG_ADDR_W-1:0]      exRt,
    output logic [`REG_ADDR_W-1:0]      exDest,
    output instrClassT                  memClass,
    output logic [`REG_ADDR_W-1:0]      memDest,
    output instrClassT                  wbClass,
    output logic [`REG_ADDR_W-1:0]      wbDest
);

    // REDIRECT itself blocks one cycle, the timer covers the rest
    localparam logic [`HOLD_W-1:0] JumpReload   = `JUMP_HOLD - 1;
    localparam logic [`HOLD_W-1:0] BranchReload = `BRANCH_HOLD - 1;

    seqStateT nextState;
    logic     isBranch;
    logic     isJump;

    assign isBranch   = instrClass inside {CLS_BEQ, CLS_BNE, CLS_BGTZ};
    assign isJump     = instrClass inside {CLS_JUMP, CLS_JR};
    assign instrReady = (state == RUN) && !timerBusy && !loadUse;
    assign accept     = instrValid && instrReady;
    assign timerLoad  = (accept && isJump) || branchTaken;
    assign timerValue = branchTaken ? BranchReload : JumpReload;

    always_comb
    begin
        nextState = state;
        case (state)
            RUN:
            begin
                if (accept && isBranch)
                    nextState = BRANCH_WAIT;
                else if (accept && isJump)
                    nextState = REDIRECT;
            end
            BRANCH_WAIT: nextState = branchTaken ? REDIRECT : RUN;  // one cycle only
            REDIRECT:    nextState = timerBusy ? REDIRECT : RUN;
            default:     nextState = RUN;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // state and slot classes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= REDIRECT;   // leaves once the idle timer is seen
            exClass  <= CLS_NONE;
            memClass <= CLS_NONE;
            wbClass  <= CLS_NONE;
        end
        else
        begin
            state    <= nextState;
            exClass  <= accept ? instrClass : CLS_NONE;  // bubble on stall
            memClass <= exClass;
            wbClass  <= memClass;
        end
    end

    // slot addresses, qualified by the classes above
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            exRs   <= rsAddr;
            exRt   <= rtAddr;
            exDest <= destAddr;
        end
        memDest <= exDest;
        wbDest  <= memDest;
    end

    // hold timer only runs while fetch is redirected
    assert property (@(posedge clk) disable iff (!rst_n) timerBusy |-> state == REDIRECT)
        else $error("redirect timer counting outside REDIRECT");

endmodule

`default_nettype wire

//--- verilog/pipe_defs.svh
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

`define REG_ADDR_W      5       // register file address
`define INSTR_W         32      // instruction word

////////////////////////////////////////////////////////////////////////////
// fetch blocking after a redirect
////////////////////////////////////////////////////////////////////////////

`define HOLD_W          2       // redirect timer width
`define JUMP_HOLD       2       // blocked cycles after j / jr
`define BRANCH_HOLD     1       // blocked cycles after a taken branch

`endif

//--- verilog/redirectTimer.sv
`timescale 1ns/1ns
`default_nettype none
`include "pipe_defs.svh"

module redirectTimer
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 load,
    input  wire [`HOLD_W-1:0]   value,
    output logic                busy
);

    logic [`HOLD_W-1:0] count;

    assign busy = (count != '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            count <= '0;
        else if (load)
            count <= value;         // zero load leaves it idle
        else if (busy)
            count <= count - 1'b1;
    end

    // sequencer only redirects with fetch open, so a reload never cuts a hold
    assert property (@(posedge clk) disable iff (!rst_n) load |-> !busy)
        else $error("redirect timer reloaded while still counting");

endmodule

`default_nettype wire
